/* common/ex_macros.svh */
// execute stage widths, alusel group codes, aluop codes
// and the multiplier iteration count

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

`define EX_WORD_W       32
`define EX_REG_ADDR_W   5
`define EX_ALUOP_W      8
`define EX_ALUSEL_W     3

// alusel groups
`define SEL_LOGIC       3'b001
`define SEL_SHIFT       3'b010
`define SEL_MOVE        3'b011
`define SEL_ARITHMETIC  3'b100

// aluop codes
`define OP_NOP          8'b0000_0000
`define OP_AND          8'b0010_0100
`define OP_OR           8'b0010_0101
`define OP_XOR          8'b0010_0110
`define OP_NOR          8'b0010_0111
`define OP_ANDI         8'b0101_1001
`define OP_ORI          8'b0101_1010
`define OP_XORI         8'b0101_1011
`define OP_LUI          8'b0101_1100
`define OP_SLL          8'b0111_1100
`define OP_SLLV         8'b0000_0100
`define OP_SRL          8'b0000_0010
`define OP_SRLV         8'b0000_0110
`define OP_SRA          8'b0000_0011
`define OP_SRAV         8'b0000_0111
`define OP_MOVZ         8'b0000_1010
`define OP_MOVN         8'b0000_1011
`define OP_MFHI         8'b0001_0000
`define OP_MTHI         8'b0001_0001
`define OP_MFLO         8'b0001_0010
`define OP_MTLO         8'b0001_0011
`define OP_SLT          8'b0010_1010
`define OP_SLTU         8'b0010_1011
`define OP_SLTI         8'b0101_0111
`define OP_SLTIU        8'b0101_1000
`define OP_ADD          8'b0010_0000
`define OP_ADDU         8'b0010_0001
`define OP_SUB          8'b0010_0010
`define OP_SUBU         8'b0010_0011
`define OP_ADDI         8'b0101_0101
`define OP_ADDIU        8'b0101_0110
`define OP_CLZ          8'b1011_0000
`define OP_CLO          8'b1011_0001
`define OP_MULT         8'b0001_1000
`define OP_MULTU        8'b0001_1001
`define OP_MUL          8'b1010_1001

// shift-add iterations per multiply
`define MUL_STEPS       32

`endif

/* common/ex_pkg.sv */
// shared vector types for the execute unit
// unit class and result handshake state enums

`include "ex_macros.svh"

package ex_pkg;

	// data path vectors
	typedef logic [`EX_WORD_W-1:0]     word_t;
	typedef logic [2*`EX_WORD_W-1:0]   dword_t;
	typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

	// operation encoding
	typedef logic [`EX_ALUOP_W-1:0]    aluop_t;
	typedef logic [`EX_ALUSEL_W-1:0]   alusel_t;

	// which block finishes an operation
	typedef enum logic [1:0] {
		UNIT_ALU,
		UNIT_MUL,
		UNIT_HI_LO_WRITE,
		UNIT_NONE
	} unit_e;

	// req/ack result machine
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL_WAIT,
		ST_ACK
	} res_state_e;

endpackage

/* multiplier/mul_iter.sv */
// iterative shift-add multiplier, 32x32 to 64 bits
// signed mode works on magnitudes and fixes the sign at the end

`timescale 1ns/1ps
`include "ex_macros.svh"

module mul_iter import ex_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   start_i,
	input  logic   signed_i,
	input  word_t  a_i,
	input  word_t  b_i,
	output logic   done_o,
	output dword_t product_o
);

	localparam int CNT_W = $clog2(`MUL_STEPS);
	localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MUL_STEPS - 1);

	word_t            a_mag;
	word_t            b_mag;
	dword_t           acc;
	dword_t           mcand;
	word_t            mplier;
	logic [CNT_W-1:0] step_cnt;
	logic             sign_diff;
	logic             busy;
	logic             finish;
	logic             wait_low;

	assign a_mag = (signed_i && a_i[31]) ? (~a_i + 1'b1) : a_i;
	assign b_mag = (signed_i && b_i[31]) ? (~b_i + 1'b1) : b_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			finish   <= 1'b0;
			wait_low <= 1'b0;
			done_o   <= 1'b0;
		end else begin
			done_o <= 1'b0;
			finish <= 1'b0;
			if (busy) begin
				// one partial product per cycle, lsb of the multiplier first
				if (mplier[0])
					acc <= acc + mcand;
				mcand    <= mcand << 1;
				mplier   <= mplier >> 1;
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == LAST_STEP) begin
					busy   <= 1'b0;
					finish <= 1'b1;
				end
			end else if (finish) begin
				product_o <= sign_diff ? (~acc + 1'b1) : acc;
				done_o    <= 1'b1;
				wait_low  <= 1'b1;
			end else if (wait_low) begin
				// start must drop before the next operation
				if (!start_i)
					wait_low <= 1'b0;
			end else if (start_i) begin
				acc       <= '0;
				mcand     <= dword_t'(a_mag);
				mplier    <= b_mag;
				sign_diff <= signed_i & (a_i[31] ^ b_i[31]);
				step_cnt  <= '0;
				busy      <= 1'b1;
			end
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# compile the execute unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_ex_unit \
	-Mdir obj_dir -o tb_ex_unit
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/tb_ex_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass message not found"
exit 1

/* source/alu_core.sv */
// single-cycle alu results
// logic, shift, add/sub with overflow, compares, counts and moves

`timescale 1ns/1ps
`include "ex_macros.svh"

module alu_core import ex_pkg::*; (
	input  aluop_t alu_kind_i,
	input  word_t  reg1_i,
	input  word_t  reg2_i,
	input  word_t  hi_i,
	input  word_t  lo_i,
	output word_t  result_o,
	output logic   overflow_o,
	output logic   write_ok_o
);

	logic [4:0] shamt;
	word_t      sum;
	word_t      diff;
	logic       add_ovf;
	logic       sub_ovf;

	// number of zero bits above the first one
	function automatic word_t lead_zeros(input word_t v);
		word_t n;
		logic  hit;
		n   = '0;
		hit = 1'b0;
		for (int i = `EX_WORD_W - 1; i >= 0; i--) begin
			if (v[i])
				hit = 1'b1;
			else if (!hit)
				n = n + 1'b1;
		end
		return n;
	endfunction

	assign shamt = reg1_i[4:0];
	assign sum   = reg1_i + reg2_i;
	assign diff  = reg1_i - reg2_i;

	// same-sign inputs with a flipped result sign
	assign add_ovf = (reg1_i[31] == reg2_i[31]) && (sum[31] != reg1_i[31]);
	assign sub_ovf = (reg1_i[31] != reg2_i[31]) && (diff[31] != reg1_i[31]);

	always_comb begin
		result_o   = '0;
		overflow_o = 1'b0;
		write_ok_o = 1'b1;
		case (alu_kind_i)
			`OP_OR, `OP_ORI:        result_o = reg1_i | reg2_i;
			`OP_AND, `OP_ANDI:      result_o = reg1_i & reg2_i;
			`OP_XOR, `OP_XORI:      result_o = reg1_i ^ reg2_i;
			`OP_NOR:                result_o = ~(reg1_i | reg2_i);
			`OP_LUI:                result_o = reg1_i;
			`OP_SLL, `OP_SLLV:      result_o = reg2_i << shamt;
			`OP_SRL, `OP_SRLV:      result_o = reg2_i >> shamt;
			`OP_SRA, `OP_SRAV:      result_o = word_t'($signed(reg2_i) >>> shamt);
			`OP_ADDU, `OP_ADDIU:    result_o = sum;
			`OP_SUBU:               result_o = diff;
			`OP_ADD, `OP_ADDI: begin
				result_o   = sum;
				overflow_o = add_ovf;
			end
			`OP_SUB: begin
				result_o   = diff;
				overflow_o = sub_ovf;
			end
			`OP_SLT, `OP_SLTI:      result_o = word_t'($signed(reg1_i) < $signed(reg2_i));
			`OP_SLTU, `OP_SLTIU:    result_o = word_t'(reg1_i < reg2_i);
			`OP_CLZ:                result_o = lead_zeros(reg1_i);
			`OP_CLO:                result_o = lead_zeros(~reg1_i);
			`OP_MFHI:               result_o = hi_i;
			`OP_MFLO:               result_o = lo_i;
			`OP_MOVN: begin
				result_o   = reg1_i;
				write_ok_o = (reg2_i != '0);
			end
			`OP_MOVZ: begin
				result_o   = reg1_i;
				write_ok_o = (reg2_i == '0);
			end
			default: ;
		endcase
		if (overflow_o)
			write_ok_o = 1'b0;
	end

endmodule

/* source/ex_decode.sv */
// alusel/aluop decoder
// picks the finishing unit and the multiply and hi/lo flags

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_decode import ex_pkg::*; (
	input  alusel_t alusel_i,
	input  aluop_t  aluop_i,
	output unit_e   unit_o,
	output aluop_t  alu_kind_o,
	output logic    mul_signed_o,
	output logic    mul_to_hilo_o,
	output logic    hilo_sel_o
);

	always_comb begin
		unit_o        = UNIT_NONE;
		alu_kind_o    = `OP_NOP;
		mul_signed_o  = 1'b0;
		mul_to_hilo_o = 1'b0;
		hilo_sel_o    = 1'b0;
		case (alusel_i)
			`SEL_LOGIC: begin
				case (aluop_i)
					`OP_OR, `OP_ORI, `OP_AND, `OP_ANDI,
					`OP_XOR, `OP_XORI, `OP_NOR, `OP_LUI: begin
						unit_o     = UNIT_ALU;
						alu_kind_o = aluop_i;
					end
					default: ;
				endcase
			end
			`SEL_SHIFT: begin
				case (aluop_i)
					`OP_SLL, `OP_SLLV, `OP_SRL, `OP_SRLV, `OP_SRA, `OP_SRAV: begin
						unit_o     = UNIT_ALU;
						alu_kind_o = aluop_i;
					end
					default: ;
				endcase
			end
			`SEL_MOVE: begin
				case (aluop_i)
					`OP_MFHI, `OP_MFLO, `OP_MOVN, `OP_MOVZ: begin
						unit_o     = UNIT_ALU;
						alu_kind_o = aluop_i;
					end
					// hilo_sel high means the HI half
					`OP_MTHI: begin
						unit_o     = UNIT_HI_LO_WRITE;
						hilo_sel_o = 1'b1;
					end
					`OP_MTLO: unit_o = UNIT_HI_LO_WRITE;
					default: ;
				endcase
			end
			`SEL_ARITHMETIC: begin
				case (aluop_i)
					`OP_ADD, `OP_ADDI, `OP_ADDU, `OP_ADDIU, `OP_SUB, `OP_SUBU,
					`OP_SLT, `OP_SLTI, `OP_SLTU, `OP_SLTIU, `OP_CLZ, `OP_CLO: begin
						unit_o     = UNIT_ALU;
						alu_kind_o = aluop_i;
					end
					`OP_MULT: begin
						unit_o        = UNIT_MUL;
						mul_signed_o  = 1'b1;
						mul_to_hilo_o = 1'b1;
					end
					`OP_MULTU: begin
						unit_o        = UNIT_MUL;
						mul_to_hilo_o = 1'b1;
					end
					// low word of the signed product goes to the register file
					`OP_MUL: begin
						unit_o       = UNIT_MUL;
						mul_signed_o = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

/* source/ex_result.sv */
// req/ack result stage with the hi/lo register pair
// write-back selection and registered outputs

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_result import ex_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req_i,
	input  unit_e     unit_i,
	input  logic      mul_to_hilo_i,
	input  logic      hilo_sel_i,
	input  word_t     alu_result_i,
	input  logic      alu_overflow_i,
	input  logic      alu_write_ok_i,
	input  logic      mul_done_i,
	input  dword_t    mul_product_i,
	input  word_t     reg1_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	output logic      mul_start_o,
	output word_t     hi_o,
	output word_t     lo_o,
	output logic      ack_o,
	output word_t     wdata_o,
	output reg_addr_t wd_o,
	output logic      wreg_o,
	output logic      overflow_o
);

	res_state_e state;
	logic       wb_en;
	word_t      wb_data;
	logic       wb_ovf;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write-back selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		wb_en   = 1'b0;
		wb_data = alu_result_i;
		wb_ovf  = 1'b0;
		case (unit_i)
			UNIT_ALU: begin
				wb_en  = wreg_i & alu_write_ok_i;
				wb_ovf = alu_overflow_i;
			end
			UNIT_MUL: begin
				wb_en   = wreg_i & ~mul_to_hilo_i;
				wb_data = mul_product_i[`EX_WORD_W-1:0];
			end
			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake FSM and hi/lo
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_IDLE;
			ack_o       <= 1'b0;
			wreg_o      <= 1'b0;
			overflow_o  <= 1'b0;
			mul_start_o <= 1'b0;
			hi_o        <= '0;
			lo_o        <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_i && unit_i == UNIT_MUL) begin
						mul_start_o <= 1'b1;
						state       <= ST_MUL_WAIT;
					end else if (req_i) begin
						if (unit_i == UNIT_HI_LO_WRITE && hilo_sel_i)
							hi_o <= reg1_i;
						else if (unit_i == UNIT_HI_LO_WRITE)
							lo_o <= reg1_i;
						wdata_o    <= wb_data;
						wreg_o     <= wb_en;
						wd_o       <= wb_en ? wd_i : '0;
						overflow_o <= wb_ovf;
						ack_o      <= 1'b1;
						state      <= ST_ACK;
					end
				end
				ST_MUL_WAIT: begin
					if (mul_done_i) begin
						if (mul_to_hilo_i)
							{hi_o, lo_o} <= mul_product_i;
						mul_start_o <= 1'b0;
						wdata_o     <= wb_data;
						wreg_o      <= wb_en;
						wd_o        <= wb_en ? wd_i : '0;
						overflow_o  <= 1'b0;
						ack_o       <= 1'b1;
						state       <= ST_ACK;
					end
				end
				ST_ACK: begin
					// results hold until the requester lets go
					if (!req_i) begin
						ack_o <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* source/ex_unit.sv */
// execute unit top level
// connects decode, alu, iterative multiplier and result stage

`timescale 1ns/1ps

module ex_unit import ex_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req_i,
	output logic      ack_o,
	input  alusel_t   alusel_i,
	input  aluop_t    aluop_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	output word_t     wdata_o,
	output reg_addr_t wd_o,
	output logic      wreg_o,
	output logic      overflow_o
);

	unit_e  unit;
	aluop_t alu_kind;
	logic   mul_signed;
	logic   mul_to_hilo;
	logic   hilo_sel;
	word_t  alu_result;
	logic   alu_overflow;
	logic   alu_write_ok;
	logic   mul_start;
	logic   mul_done;
	dword_t mul_product;
	word_t  hi_q;
	word_t  lo_q;

	ex_decode u_decode (
		.alusel_i      (alusel_i),
		.aluop_i       (aluop_i),
		.unit_o        (unit),
		.alu_kind_o    (alu_kind),
		.mul_signed_o  (mul_signed),
		.mul_to_hilo_o (mul_to_hilo),
		.hilo_sel_o    (hilo_sel)
	);

	alu_core u_alu (
		.alu_kind_i (alu_kind),
		.reg1_i     (reg1_i),
		.reg2_i     (reg2_i),
		.hi_i       (hi_q),
		.lo_i       (lo_q),
		.result_o   (alu_result),
		.overflow_o (alu_overflow),
		.write_ok_o (alu_write_ok)
	);

	mul_iter u_mul (
		.clk       (clk),
		.rst       (rst),
		.start_i   (mul_start),
		.signed_i  (mul_signed),
		.a_i       (reg1_i),
		.b_i       (reg2_i),
		.done_o    (mul_done),
		.product_o (mul_product)
	);

	ex_result u_result (
		.clk            (clk),
		.rst            (rst),
		.req_i          (req_i),
		.unit_i         (unit),
		.mul_to_hilo_i  (mul_to_hilo),
		.hilo_sel_i     (hilo_sel),
		.alu_result_i   (alu_result),
		.alu_overflow_i (alu_overflow),
		.alu_write_ok_i (alu_write_ok),
		.mul_done_i     (mul_done),
		.mul_product_i  (mul_product),
		.reg1_i         (reg1_i),
		.wd_i           (wd_i),
		.wreg_i         (wreg_i),
		.mul_start_o    (mul_start),
		.hi_o           (hi_q),
		.lo_o           (lo_q),
		.ack_o          (ack_o),
		.wdata_o        (wdata_o),
		.wd_o           (wd_o),
		.wreg_o         (wreg_o),
		.overflow_o     (overflow_o)
	);

endmodule

/* verification/tb_ex_checks.svh */
// reference model of the execute unit results
// concurrent checks on the outputs and the req/ack handshake

`ifndef TB_EX_CHECKS_SVH
`define TB_EX_CHECKS_SVH

// leading bits equal to lead_bit, counted down from the msb
function automatic word_t leading_run(input word_t v, input logic lead_bit);
	int n;
	n = 0;
	while (n < 32 && v[31-n] == lead_bit)
		n++;
	return word_t'(n);
endfunction

function automatic logic overflow_expect(input aluop_t op, input word_t a, input word_t b);
	longint wide;
	wide = longint'($signed(a));
	if (op == `OP_SUB)
		wide = wide - longint'($signed(b));
	else
		wide = wide + longint'($signed(b));
	if (op != `OP_ADD && op != `OP_ADDI && op != `OP_SUB)
		return 1'b0;
	return (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
endfunction

function automatic logic write_expected(input aluop_t op, input word_t a, input word_t b);
	if (op == `OP_MOVN && b == '0)
		return 1'b0;
	if (op == `OP_MOVZ && b != '0)
		return 1'b0;
	return !overflow_expect(op, a, b);
endfunction

function automatic word_t alu_expect(input aluop_t op, input word_t a, input word_t b,
		input word_t hi, input word_t lo);
	logic [63:0] ext;
	ext = {{32{b[31]}}, b} >> a[4:0];
	case (op)
		`OP_OR, `OP_ORI:                        return a | b;
		`OP_AND, `OP_ANDI:                      return a & b;
		`OP_XOR, `OP_XORI:                      return a ^ b;
		`OP_NOR:                                return ~(a | b);
		`OP_LUI, `OP_MOVN, `OP_MOVZ:            return a;
		`OP_SLL, `OP_SLLV:                      return b << a[4:0];
		`OP_SRL, `OP_SRLV:                      return b >> a[4:0];
		`OP_SRA, `OP_SRAV:                      return ext[31:0];
		`OP_ADD, `OP_ADDI, `OP_ADDU, `OP_ADDIU: return a + b;
		`OP_SUB, `OP_SUBU:                      return a - b;
		// mixed signs decide by the sign bit alone
		`OP_SLT, `OP_SLTI:   return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
		`OP_SLTU, `OP_SLTIU: return {31'b0, a < b};
		`OP_CLZ:             return leading_run(a, 1'b0);
		`OP_CLO:             return leading_run(a, 1'b1);
		`OP_MFHI:            return hi;
		`OP_MFLO:            return lo;
		default:             return '0;
	endcase
endfunction

function automatic dword_t product_expect(input logic is_signed, input word_t a, input word_t b);
	if (is_signed)
		return dword_t'($signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b}));
	return {32'b0, a} * {32'b0, b};
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result checks, taken on the rising edge of ack_o
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

wdata_check: assert property (@(posedge clk) $rose(ack_o) && exp_wreg |-> wdata_o == exp_wdata)
	else report_mismatch("wdata_o", exp_wdata, wdata_o);
wreg_check: assert property (@(posedge clk) $rose(ack_o) |-> wreg_o == exp_wreg)
	else report_mismatch("wreg_o", word_t'(exp_wreg), word_t'(wreg_o));
wd_check: assert property (@(posedge clk) $rose(ack_o) |-> wd_o == exp_wd)
	else report_mismatch("wd_o", word_t'(exp_wd), word_t'(wd_o));
ovf_check: assert property (@(posedge clk) $rose(ack_o) |-> overflow_o == exp_ovf)
	else report_mismatch("overflow_o", word_t'(exp_ovf), word_t'(overflow_o));

// handshake rules
reset_ack_check: assert property (@(posedge clk) $past(rst) |-> !ack_o)
	else report_mismatch("ack_o", '0, word_t'(ack_o));
hold_check: assert property (@(posedge clk) ack_o && $past(ack_o) |->
		$stable(wdata_o) && $stable(wd_o) && $stable(wreg_o) && $stable(overflow_o))
	else report_problem("outputs changed while ack_o was held high");
drop_check: assert property (@(posedge clk) $past(ack_o) && !$past(req_i) |-> !ack_o)
	else report_mismatch("ack_o", '0, word_t'(ack_o));
latency_check: assert property (@(posedge clk)
		$past(req_i) && !$past(ack_o) && $past(exp_fast) |-> ack_o)
	else report_problem("single-cycle operation was not acknowledged one cycle after req_i");

`endif

/* verification/tb_ex_unit.sv */
// testbench top for the execute unit
// clock, reset, four-phase request driver, stimulus and watchdog

`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_unit import ex_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	localparam int LOGIC_ROUNDS = 4;
	localparam int MUL_ROUNDS   = 4;
	// overflow, compare, count, hi/lo, move, disabled-write and unknown-code cases
	localparam int FIXED_OPS    = 36;
	localparam int N_OPS        = LOGIC_ROUNDS * 14 + MUL_ROUNDS * 7 + FIXED_OPS;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + N_OPS * (`MUL_STEPS + 10)) * CLK_PERIOD;

	localparam aluop_t LOGIC_OPS [14] = '{`OP_OR, `OP_ORI, `OP_AND, `OP_ANDI, `OP_XOR,
		`OP_XORI, `OP_NOR, `OP_LUI, `OP_SLL, `OP_SLLV, `OP_SRL, `OP_SRLV, `OP_SRA, `OP_SRAV};
	localparam word_t COUNT_VALUES [5] = '{32'h0, 32'hffff_ffff, 32'h1, 32'h0001_0000,
		32'h8000_0000};

	logic      clk;
	logic      rst;
	logic      req_i;
	logic      ack_o;
	alusel_t   alusel_i;
	aluop_t    aluop_i;
	word_t     reg1_i;
	word_t     reg2_i;
	reg_addr_t wd_i;
	logic      wreg_i;
	word_t     wdata_o;
	reg_addr_t wd_o;
	logic      wreg_o;
	logic      overflow_o;

	// expected response of the operation in flight
	word_t     exp_wdata;
	logic      exp_wreg;
	reg_addr_t exp_wd;
	logic      exp_ovf;
	logic      exp_fast;
	word_t     exp_hi;
	word_t     exp_lo;

	ex_unit DUT (
		.clk        (clk),
		.rst        (rst),
		.req_i      (req_i),
		.ack_o      (ack_o),
		.alusel_i   (alusel_i),
		.aluop_i    (aluop_i),
		.reg1_i     (reg1_i),
		.reg2_i     (reg2_i),
		.wd_i       (wd_i),
		.wreg_i     (wreg_i),
		.wdata_o    (wdata_o),
		.wd_o       (wd_o),
		.wreg_o     (wreg_o),
		.overflow_o (overflow_o)
	);

	task automatic stop_on_failure();
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
		stop_on_failure();
	endtask

	task automatic report_problem(input string what);
		$display("%0t %s", $time, what);
		stop_on_failure();
	endtask

	`include "tb_ex_checks.svh"

	// one full four-phase exchange with the expected values set up front
	task automatic run_op(input alusel_t sel, input aluop_t op, input word_t a, input word_t b);
		dword_t      prod;
		logic        is_mul;
		int unsigned hold;
		is_mul = (sel == `SEL_ARITHMETIC) && (op == `OP_MULT || op == `OP_MULTU || op == `OP_MUL);
		@(posedge clk);
		#1;
		alusel_i  = sel;
		aluop_i   = op;
		reg1_i    = a;
		reg2_i    = b;
		wd_i      = reg_addr_t'($urandom_range(31, 1));
		exp_fast  = !is_mul;
		exp_ovf   = 1'b0;
		exp_wreg  = 1'b0;
		exp_wdata = alu_expect(op, a, b, exp_hi, exp_lo);
		if (is_mul) begin
			prod      = product_expect(op != `OP_MULTU, a, b);
			exp_wdata = prod[31:0];
			exp_wreg  = (op == `OP_MUL);
			if (op != `OP_MUL)
				{exp_hi, exp_lo} = prod;
		end else if (sel == `SEL_MOVE && op == `OP_MTHI) begin
			exp_hi = a;
		end else if (sel == `SEL_MOVE && op == `OP_MTLO) begin
			exp_lo = a;
		end else if (sel != 3'b111) begin
			exp_ovf  = overflow_expect(op, a, b);
			exp_wreg = write_expected(op, a, b);
		end
		// no register write is requested when wreg_i is low
		exp_wreg = exp_wreg & wreg_i;
		exp_wd = exp_wreg ? wd_i : '0;
		req_i  = 1'b1;
		while (!ack_o) begin
			@(posedge clk);
			#1;
		end
		// back-pressure, keep req_i up a few more cycles
		hold = $urandom_range(3, 0);
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		req_i = 1'b0;
		while (ack_o) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the DUT stopped answering before all operations were done");
		stop_on_failure();
	end

	initial begin
		word_t a;
		word_t b;
		void'($urandom(84879));
		rst       = 1'b1;
		req_i     = 1'b0;
		alusel_i  = '0;
		aluop_i   = '0;
		reg1_i    = '0;
		reg2_i    = '0;
		wd_i      = '0;
		wreg_i    = 1'b1;
		exp_wdata = '0;
		exp_wreg  = 1'b0;
		exp_wd    = '0;
		exp_ovf   = 1'b0;
		exp_fast  = 1'b0;
		exp_hi    = '0;
		exp_lo    = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// logic and shift group, odd rounds shift negative values
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		for (int r = 0; r < LOGIC_ROUNDS; r++) begin
			for (int i = 0; i < 14; i++) begin
				b = $urandom();
				if (r % 2 == 1)
					b[31] = 1'b1;
				run_op((i < 8) ? `SEL_LOGIC : `SEL_SHIFT, LOGIC_OPS[i], $urandom(), b);
			end
		end

		// signed overflow next to the wrapping forms
		run_op(`SEL_ARITHMETIC, `OP_ADD, 32'h7fff_ffff, 32'h1);
		run_op(`SEL_ARITHMETIC, `OP_ADDU, 32'h7fff_ffff, 32'h1);
		run_op(`SEL_ARITHMETIC, `OP_ADD, 32'h8000_0000, 32'h8000_0000);
		run_op(`SEL_ARITHMETIC, `OP_ADDU, 32'h8000_0000, 32'h8000_0000);
		run_op(`SEL_ARITHMETIC, `OP_ADDI, 32'h7fff_ffff, 32'h7fff_ffff);
		run_op(`SEL_ARITHMETIC, `OP_SUB, 32'h8000_0000, 32'h1);
		run_op(`SEL_ARITHMETIC, `OP_SUBU, 32'h8000_0000, 32'h1);
		run_op(`SEL_ARITHMETIC, `OP_SUB, 32'h7fff_ffff, 32'hffff_ffff);
		run_op(`SEL_ARITHMETIC, `OP_SUBU, 32'h7fff_ffff, 32'hffff_ffff);
		run_op(`SEL_ARITHMETIC, `OP_ADD, 32'h10, 32'h20);

		// compares on mixed signs, then counts
		run_op(`SEL_ARITHMETIC, `OP_SLT, 32'hffff_ffff, 32'h1);
		run_op(`SEL_ARITHMETIC, `OP_SLTU, 32'hffff_ffff, 32'h1);
		run_op(`SEL_ARITHMETIC, `OP_SLT, 32'h1, 32'hffff_ffff);
		run_op(`SEL_ARITHMETIC, `OP_SLTU, 32'h1, 32'hffff_ffff);
		a = $urandom();
		b = $urandom();
		run_op(`SEL_ARITHMETIC, `OP_SLT, a, b);
		run_op(`SEL_ARITHMETIC, `OP_SLTU, a, b);
		for (int i = 0; i < 5; i++) begin
			run_op(`SEL_ARITHMETIC, `OP_CLZ, COUNT_VALUES[i], '0);
			run_op(`SEL_ARITHMETIC, `OP_CLO, COUNT_VALUES[i], '0);
		end

		// multiplies, both negative in round 0 and one negative in round 1
		for (int r = 0; r < MUL_ROUNDS; r++) begin
			a = $urandom();
			b = $urandom();
			if (r == 0)
				b[31] = 1'b1;
			if (r < 2)
				a[31] = 1'b1;
			run_op(`SEL_ARITHMETIC, `OP_MULT, a, b);
			run_op(`SEL_MOVE, `OP_MFHI, '0, '0);
			run_op(`SEL_MOVE, `OP_MFLO, '0, '0);
			run_op(`SEL_ARITHMETIC, `OP_MULTU, a, b);
			run_op(`SEL_MOVE, `OP_MFHI, '0, '0);
			run_op(`SEL_MOVE, `OP_MFLO, '0, '0);
			run_op(`SEL_ARITHMETIC, `OP_MUL, a, b);
		end

		// hi/lo writes and conditional moves
		a = $urandom();
		b = $urandom();
		run_op(`SEL_MOVE, `OP_MTHI, a, '0);
		run_op(`SEL_MOVE, `OP_MTLO, b, '0);
		run_op(`SEL_MOVE, `OP_MFHI, '0, '0);
		run_op(`SEL_MOVE, `OP_MFLO, '0, '0);
		run_op(`SEL_MOVE, `OP_MOVN, a, 32'h4);
		run_op(`SEL_MOVE, `OP_MOVN, a, '0);
		run_op(`SEL_MOVE, `OP_MOVZ, b, '0);
		run_op(`SEL_MOVE, `OP_MOVZ, b, 32'h4);
		// a valid operation without a register write request
		wreg_i = 1'b0;
		run_op(`SEL_ARITHMETIC, `OP_ADDU, a, b);
		wreg_i = 1'b1;
		// unknown group code acknowledges without a write
		run_op(3'b111, `OP_OR, a, b);

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
+incdir+verification
common/ex_pkg.sv
source/ex_decode.sv
source/alu_core.sv
multiplier/mul_iter.sv
source/ex_result.sv
source/ex_unit.sv
verification/tb_ex_unit.sv
